/* hdl/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Integer register width
`define RV_XLEN 64

// Architectural registers, x0 included
`define RV_NREGS 32

// First instruction address after reset
`define RV_RESET_PC 64'h0000_0000_0000_1000

`endif

/* hdl/rv_pkg.sv */
`include "rv_consts.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [31:0] u32;
    typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP        = 7'b0110011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_OP_32     = 7'b0111011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_ADDW = 4'd5,
        ALU_SUBW = 4'd6
    } alu_op_e;

    typedef struct packed {
        alu_op_e  alu_op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     use_imm;
        word_t    imm;     // Already sign-extended
        logic     wen;
        logic     illegal;
    } dec_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        u32       insn;
        reg_idx_t rd;
        logic     wen;
        word_t    wdata;
        logic     illegal;
    } commit_t;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        word_t adr;
    } wb_req_t;

    typedef struct packed {
        logic ack;
        u32   dat;
    } wb_rsp_t;

endpackage

/* hdl/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
    input  rv_pkg::u32   insn,
    output rv_pkg::dec_t dec
);
    import rv_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = insn[14:12];
    assign funct7 = insn[31:25];

    always_comb begin
        dec         = '0;
        dec.alu_op  = ALU_ADD;
        dec.rd      = insn[11:7];
        dec.rs1     = insn[19:15];
        dec.rs2     = insn[24:20];
        dec.imm     = {{52{insn[31]}}, insn[31:20]}; // I-type
        dec.illegal = 1'b1;

        case (insn[6:0])
            OPC_OP: begin
                dec.illegal = 1'b0;
                case ({funct3, funct7})
                    {3'h0, 7'h00}: dec.alu_op = ALU_ADD;
                    {3'h0, 7'h20}: dec.alu_op = ALU_SUB;
                    {3'h7, 7'h00}: dec.alu_op = ALU_AND;
                    {3'h6, 7'h00}: dec.alu_op = ALU_OR;
                    {3'h4, 7'h00}: dec.alu_op = ALU_XOR;
                    default:       dec.illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                dec.illegal = 1'b0;
                dec.use_imm = 1'b1;
                case (funct3)
                    3'h0:    dec.alu_op = ALU_ADD; // ADDI
                    3'h4:    dec.alu_op = ALU_XOR;
                    3'h6:    dec.alu_op = ALU_OR;
                    3'h7:    dec.alu_op = ALU_AND;
                    default: dec.illegal = 1'b1;   // Shifts, compares
                endcase
            end
            OPC_OP_IMM_32: begin
                dec.use_imm = 1'b1;
                dec.alu_op  = ALU_ADDW;
                dec.illegal = (funct3 != 3'h0);    // ADDIW only
            end
            OPC_OP_32: begin
                dec.illegal = 1'b0;
                case ({funct3, funct7})
                    {3'h0, 7'h00}: dec.alu_op = ALU_ADDW;
                    {3'h0, 7'h20}: dec.alu_op = ALU_SUBW;
                    default:       dec.illegal = 1'b1;
                endcase
            end
            default: dec.illegal = 1'b1;
        endcase

        dec.wen = !dec.illegal;
    end

endmodule

/* hdl/rv_regfile.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_regfile (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data,
    input  logic             we,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::word_t    wdata
);
    import rv_pkg::*;

    word_t regs [1:`RV_NREGS-1]; // No storage behind x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* hdl/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::alu_op_e op,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    output rv_pkg::word_t   result
);
    import rv_pkg::*;

    u32 add_w;
    u32 sub_w;

    // Word ops only look at the low halves
    assign add_w = a[31:0] + b[31:0];
    assign sub_w = a[31:0] - b[31:0];

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_ADDW: begin
                result = {{32{add_w[31]}}, add_w}; // Also ADDIW
            end
            ALU_SUBW: begin
                result = {{32{sub_w[31]}}, sub_w};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* hdl/rv_fetch.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_fetch (
    input  logic            clk,
    input  logic            rst_n,
    output rv_pkg::wb_req_t imem_req,
    input  rv_pkg::wb_rsp_t imem_rsp,
    output rv_pkg::u32      insn,
    output rv_pkg::word_t   pc,
    output logic            exec
);

    typedef enum logic {
        FETCH,
        EXEC
    } state_e;

    state_e state;
    state_e state_d;
    logic   fetch_done;

    assign fetch_done = (state == FETCH) && imem_rsp.ack;

    always_comb begin
        state_d = state;
        case (state)
            FETCH: begin
                if (imem_rsp.ack) begin
                    state_d = EXEC;
                end
            end
            EXEC: begin
                state_d = FETCH; // Single cycle execute
            end
            default: begin
                state_d = FETCH;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FETCH;
            pc    <= `RV_RESET_PC;
        end else begin
            state <= state_d;
            if (state == EXEC) begin
                pc <= pc + 64'd4;
            end
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if (fetch_done) begin
            insn <= imem_rsp.dat;
        end
    end

    // Request held until ack is seen
    always_comb begin
        imem_req.cyc = (state == FETCH);
        imem_req.stb = (state == FETCH);
        imem_req.we  = 1'b0;
        imem_req.adr = pc;
    end

    assign exec = (state == EXEC);

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
    input  logic            clk,
    input  logic            rst_n,
    output rv_pkg::wb_req_t imem_req,
    input  rv_pkg::wb_rsp_t imem_rsp,
    output rv_pkg::commit_t commit
);
    import rv_pkg::*;

    u32      insn;
    word_t   pc;
    logic    exec;
    dec_t    dec;
    word_t   rs1_data;
    word_t   rs2_data;
    word_t   op_b;
    word_t   result;
    logic    rf_we;
    commit_t commit_q;

    rv_fetch u_fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .imem_req (imem_req),
        .imem_rsp (imem_rsp),
        .insn     (insn),
        .pc       (pc),
        .exec     (exec)
    );

    rv_decoder u_decoder (
        .insn (insn),
        .dec  (dec)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .rd       (dec.rd),
        .wdata    (result)
    );

    assign op_b = dec.use_imm ? dec.imm : rs2_data;

    rv_alu u_alu (
        .op     (dec.alu_op),
        .a      (rs1_data),
        .b      (op_b),
        .result (result)
    );

    assign rf_we = exec && dec.wen && !dec.illegal && (dec.rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            commit_q <= '0;
        end else begin
            commit_q.valid <= exec; // One cycle pulse after EXEC
            if (exec) begin
                commit_q.pc      <= pc;
                commit_q.insn    <= insn;
                commit_q.rd      <= dec.rd;
                commit_q.wen     <= rf_we;
                commit_q.wdata   <= result;
                commit_q.illegal <= dec.illegal;
            end
        end
    end

    assign commit = commit_q;

endmodule

/* sim/tb_imem.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_imem (
    input  logic            clk,
    input  logic            rst_n,
    input  rv_pkg::wb_req_t req,
    output rv_pkg::wb_rsp_t rsp
);
    import rv_pkg::*;

    localparam int DEPTH = 512;

    u32         mem [0:DEPTH-1]; // Filled by the testbench before reset
    logic [1:0] wait_cnt;
    word_t      idx;

    assign idx = (req.adr - `RV_RESET_PC) >> 2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp      <= '0;
            wait_cnt <= '0;
        end else if (rsp.ack) begin
            rsp.ack  <= 1'b0;
            wait_cnt <= 2'($urandom_range(0, 3)); // Next request's delay
        end else if (req.cyc && req.stb) begin
            if (wait_cnt == 0) begin
                rsp.ack <= 1'b1;
                rsp.dat <= (idx < DEPTH) ? mem[idx] : 32'h0;
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

/* sim/tb_rv_core.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_rv_core;
    import rv_pkg::*;

    logic    clk;
    logic    rst_n;
    wb_req_t imem_req;
    wb_rsp_t imem_rsp;
    commit_t commit;

    word_t   model [0:31];
    u32      fq_insn [$];
    word_t   fq_pc [$];
    word_t   next_pc;
    int      errors;
    int      n_commit;
    int      prog_len;
    int      phase_end [5];
    string   phase_name [5];
    int      phase_idx;
    bit      built;
    logic    prev_stb;
    logic    prev_ack;
    word_t   prev_adr;
    logic [1:0] ack_hist;
    u32      exp_insn;
    word_t   exp_pc;
    bit      exp_ill;
    bit      exp_wen;
    word_t   exp_val;

    rv_core u_rv_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .imem_req (imem_req),
        .imem_rsp (imem_rsp),
        .commit   (commit)
    );

    tb_imem u_imem (
        .clk (clk),
        .rst_n (rst_n),
        .req (imem_req),
        .rsp (imem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic u32 enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                 logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic u32 enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                 logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        errors++;
        $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%s", what);
    endtask

    // Architectural result from the RISC-V rules
    task automatic predict(input u32 insn, output bit ill, output word_t val);
        word_t a;
        word_t b;
        word_t imm;
        logic [31:0] w;
        a   = model[insn[19:15]];
        b   = model[insn[24:20]];
        imm = {{52{insn[31]}}, insn[31:20]};
        ill = 1'b0;
        val = '0;
        case ({insn[6:0], insn[14:12]})
            {7'h33, 3'h0}: begin
                if (insn[31:25] == 7'h00) val = a + b;
                else if (insn[31:25] == 7'h20) val = a - b;
                else ill = 1'b1;
            end
            {7'h33, 3'h7}: begin
                if (insn[31:25] == 7'h00) val = a & b;
                else ill = 1'b1;
            end
            {7'h33, 3'h6}: begin
                if (insn[31:25] == 7'h00) val = a | b;
                else ill = 1'b1;
            end
            {7'h33, 3'h4}: begin
                if (insn[31:25] == 7'h00) val = a ^ b;
                else ill = 1'b1;
            end
            {7'h13, 3'h0}: val = a + imm;
            {7'h13, 3'h4}: val = a ^ imm;
            {7'h13, 3'h6}: val = a | imm;
            {7'h13, 3'h7}: val = a & imm;
            {7'h1b, 3'h0}: begin
                w   = a[31:0] + imm[31:0];
                val = {{32{w[31]}}, w};
            end
            {7'h3b, 3'h0}: begin
                if (insn[31:25] == 7'h00) w = a[31:0] + b[31:0];
                else if (insn[31:25] == 7'h20) w = a[31:0] - b[31:0];
                else ill = 1'b1;
                val = {{32{w[31]}}, w};
            end
            default: ill = 1'b1;
        endcase
    endtask

    task automatic put(input u32 insn);
        u_imem.mem[prog_len] = insn;
        prog_len++;
    endtask

    task automatic build_program();
        logic [2:0] f3s [4];
        f3s = '{3'h0, 3'h7, 3'h6, 3'h4};
        for (int i = 0; i < 512; i++) begin
            u_imem.mem[i] = {25'(i), 7'h7f}; // Unused words decode as illegal
        end
        for (int r = 1; r < 32; r++) begin // Seed every register
            put(enc_i(12'($urandom), 5'd0, 3'h0, 5'(r), 7'h13));
            put(enc_i(12'($urandom), 5'(r), 3'h4, 5'(r), 7'h13));
        end
        phase_end[0] = prog_len;
        for (int i = 0; i < 40; i++) begin
            if (i % 5 == 1) begin
                put(enc_r(7'h20, 5'($urandom), 5'($urandom), 3'h0, 5'($urandom), 7'h33));
            end else begin
                put(enc_r(7'h00, 5'($urandom), 5'($urandom), f3s[$urandom % 4],
                          5'($urandom), 7'h33));
            end
        end
        phase_end[1] = prog_len;
        for (int i = 0; i < 30; i++) begin
            // Sign bit alternates every round of four ops
            put(enc_i({1'(i / 4), 11'($urandom)}, 5'($urandom), f3s[i % 4],
                      5'($urandom), 7'h13));
        end
        phase_end[2] = prog_len;
        put(enc_i(12'h7ff, 5'd0, 3'h0, 5'd5, 7'h13));
        for (int i = 0; i < 20; i++) begin
            put(enc_r(7'h00, 5'd5, 5'd5, 3'h0, 5'd5, 7'h33)); // Doubling up to bit 30
        end
        put(enc_r(7'h00, 5'd5, 5'd5, 3'h0, 5'd7, 7'h3b));
        put(enc_i(12'h7ff, 5'd5, 3'h0, 5'd8, 7'h1b));
        put(enc_r(7'h20, 5'd5, 5'd0, 3'h0, 5'd9, 7'h3b));
        for (int i = 0; i < 20; i++) begin
            case (i % 3)
                0: put(enc_i(12'($urandom), 5'($urandom), 3'h0, 5'($urandom), 7'h1b));
                1: put(enc_r(7'h00, 5'($urandom), 5'($urandom), 3'h0, 5'($urandom), 7'h3b));
                default: put(enc_r(7'h20, 5'($urandom), 5'($urandom), 3'h0,
                                   5'($urandom), 7'h3b));
            endcase
        end
        phase_end[3] = prog_len;
        put(enc_i(12'h003, 5'd1, 3'h1, 5'd2, 7'h13)); // SLLI
        put(enc_i(12'h010, 5'd1, 3'h2, 5'd3, 7'h03)); // LW
        put(enc_r(7'h01, 5'd1, 5'd2, 3'h0, 5'd4, 7'h33)); // MUL
        put(enc_i(12'h001, 5'd1, 3'h1, 5'd6, 7'h1b)); // SLLIW
        put(enc_i(12'h123, 5'd1, 3'h0, 5'd0, 7'h13)); // Write to x0
        put(enc_r(7'h00, 5'd3, 5'd1, 3'h0, 5'd0, 7'h33));
        put(enc_r(7'h00, 5'd0, 5'd0, 3'h0, 5'd10, 7'h33));
        put(enc_r(7'h00, 5'd2, 5'd0, 3'h0, 5'd11, 7'h33));
        put(enc_r(7'h00, 5'd4, 5'd3, 3'h0, 5'd12, 7'h33));
        phase_end[4] = prog_len;
    endtask

    // Protocol, timing and result checks on each rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            assert (imem_req.cyc == imem_req.stb)
                else report_mismatch("imem_req.stb", imem_req.stb, imem_req.cyc);
            assert (imem_req.we == 1'b0)
                else report_mismatch("imem_req.we", imem_req.we, 0);
            if (prev_stb && !prev_ack) begin
                assert (imem_req.stb) else report_failure("stb dropped before ack");
                assert (imem_req.adr == prev_adr)
                    else report_mismatch("imem_req.adr", imem_req.adr, prev_adr);
            end
            if (prev_stb && prev_ack) begin
                assert (!imem_req.stb) else report_failure("stb still high after ack");
            end
            assert (commit.valid == ack_hist[1])
                else report_mismatch("commit.valid", commit.valid, ack_hist[1]);
            if (imem_req.stb && imem_rsp.ack) begin
                assert (imem_req.adr == next_pc)
                    else report_mismatch("imem_req.adr", imem_req.adr, next_pc);
                fq_pc.push_back(imem_req.adr);
                fq_insn.push_back(imem_rsp.dat);
                next_pc = next_pc + 64'd4;
            end
            if (commit.valid) begin
                if (fq_pc.size() == 0) begin
                    report_failure("Commit seen without a matching fetch");
                end else begin
                    exp_pc   = fq_pc.pop_front();
                    exp_insn = fq_insn.pop_front();
                    assert (commit.pc == exp_pc)
                        else report_mismatch("commit.pc", commit.pc, exp_pc);
                    assert (commit.insn == exp_insn)
                        else report_mismatch("commit.insn", commit.insn, exp_insn);
                    predict(exp_insn, exp_ill, exp_val);
                    exp_wen = !exp_ill && (exp_insn[11:7] != 5'd0);
                    assert (commit.illegal == exp_ill)
                        else report_mismatch("commit.illegal", commit.illegal, exp_ill);
                    assert (commit.wen == exp_wen)
                        else report_mismatch("commit.wen", commit.wen, exp_wen);
                    assert (commit.rd == exp_insn[11:7])
                        else report_mismatch("commit.rd", commit.rd, exp_insn[11:7]);
                    if (exp_wen) begin
                        assert (commit.wdata == exp_val)
                            else report_mismatch("commit.wdata", commit.wdata, exp_val);
                        model[exp_insn[11:7]] = exp_val;
                    end
                end
                n_commit++;
                if (phase_idx < 5 && n_commit == phase_end[phase_idx]) begin
                    $display("Test %0d %s finished, %0d errors so far", phase_idx + 1,
                             phase_name[phase_idx], errors);
                    phase_idx++;
                end
            end
        end
        prev_stb <= rst_n && imem_req.stb;
        prev_ack <= imem_rsp.ack;
        prev_adr <= imem_req.adr;
        ack_hist <= rst_n ? {ack_hist[0], imem_req.stb && imem_rsp.ack} : 2'b00;
    end

    initial begin
        int seed_ret;
        rst_n     = 1'b0;
        errors    = 0;
        n_commit  = 0;
        prog_len  = 0;
        phase_idx = 0;
        built     = 1'b0;
        prev_stb  = 1'b0;
        prev_ack  = 1'b0;
        prev_adr  = '0;
        ack_hist  = 2'b00;
        next_pc   = `RV_RESET_PC;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        phase_name = '{"protocol and setup", "register-register", "immediate forms",
                       "word forms", "illegal and x0"};
        seed_ret = $urandom(219);
        build_program();
        built = 1'b1;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        wait (n_commit >= prog_len);
        repeat (3) @(negedge clk);
        $display("Commits checked %0d, errors %0d", n_commit, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Worst case is EXEC, the registered ack and three wait states per instruction
    initial begin
        wait (built);
        #((prog_len * (3 + 3) + 50) * 4);
        $display("Timeout after %0d of %0d commits", n_commit, prog_len);
        $display("Errors found");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_fetch.sv
hdl/rv_core.sv
sim/tb_imem.sv
sim/tb_rv_core.sv
